//--- src.f
iagc_pkg.sv
iagc_sampler.sv
iagc_sample_ram.sv
iagc_controller.sv
iagc_top.sv
iagc_asserts.sv
tb_clock_gen.sv
iagc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the iagc testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module iagc_tb --Mdir obj_dir -o iagc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Let the run go on after an assertion error so the testbench reports it
./obj_dir/iagc_sim +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation run exited with status $run_status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- iagc_tb.sv
`timescale 1ns/10ps

module iagc_tb
    import iagc_pkg::*;
();

    // Clear is about 4100 cycles, every other command well under 200
    localparam int                   TIMEOUT_CYCLES = 60000;
    localparam logic [31:0]          LFSR_SEED      = 32'h9c24_1d92;
    localparam logic [DATA_SIZE-1:0] ERR_MASK       = 16'h5a5a;

    logic                 clock;
    logic                 arst_n;
    logic                 cmd_req;
    iagc_cmd_t            cmd;
    logic [DATA_SIZE-1:0] ref_sample;
    logic [DATA_SIZE-1:0] err_sample;
    logic                 gate;
    logic                 dump_ack;
    logic                 cmd_ack;
    iagc_resp_t           resp;
    iagc_status_e         status;
    logic                 dump_req;
    iagc_dump_t           dump;

    logic [31:0]          lfsr;
    int                   cycles;
    int                   checks;
    int                   errors;
    int                   test_errors;
    int                   tests_run;
    int                   tests_failed;
    string                test_name;
    logic [DATA_SIZE-1:0] dump_words[$];
    logic                 dump_lasts[$];
    logic [DATA_SIZE-1:0] ref_words[$];

    tb_clock_gen clock_gen_i (
        .o_clock  (clock),
        .o_arst_n (arst_n)
    );

    iagc_top dut_i (
        .i_clock     (clock),
        .i_arst_n    (arst_n),
        .i_cmd_req   (cmd_req),
        .i_cmd       (cmd),
        .i_reference (ref_sample),
        .i_error     (err_sample),
        .i_gate      (gate),
        .i_dump_ack  (dump_ack),
        .o_cmd_ack   (cmd_ack),
        .o_resp      (resp),
        .o_status    (status),
        .o_dump_req  (dump_req),
        .o_dump      (dump)
    );

    // Ramp and its masked twin
    always @(posedge clock) begin
        ref_sample <= ref_sample + 1'b1;
        err_sample <= (ref_sample + 1'b1) ^ ERR_MASK;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h8020_0003;
        return state >> 1;
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);   // One step per bit
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            test_errors++;
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected,
                     actual);
        end
    endtask

    task automatic check_at_least(input string what, input int low, input int actual);
        checks++;
        assert (actual >= low)
        else begin
            errors++;
            test_errors++;
            $display("** Error [%s] %s: expected at least %0d, actual %0d", test_name, what,
                     low, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("PASS  %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL  %s, %0d errors", test_name, test_errors);
        end
    endtask

    // Four-phase command, waits for the full return to idle
    task automatic send_cmd(input iagc_opcode_e op, input logic [ADDR_SIZE-1:0] value,
                            output logic err);
        @(posedge clock);
        cmd_req <= 1'b1;
        cmd     <= iagc_cmd_t'{opcode: op, arg: value};
        do @(negedge clock); while (!cmd_ack);
        err = resp.error;
        @(posedge clock);
        cmd_req <= 1'b0;
        do @(negedge clock); while (cmd_ack);
    endtask

    task automatic collect_dump();
        int   delay;
        logic done;
        dump_words.delete();
        dump_lasts.delete();
        done = 1'b0;
        while (!done) begin
            do @(negedge clock); while (!dump_req);
            dump_words.push_back(dump.data);
            dump_lasts.push_back(dump.last);
            done = dump.last;
            take_bits(2, delay);
            repeat (delay) @(posedge clock);   // Random back-pressure
            @(posedge clock);
            dump_ack <= 1'b1;
            do @(negedge clock); while (dump_req);
            take_bits(2, delay);
            repeat (delay) @(posedge clock);
            @(posedge clock);
            dump_ack <= 1'b0;
        end
    endtask

    task automatic run_dump(input iagc_opcode_e op);
        logic err;
        fork
            send_cmd(op, '0, err);
            collect_dump();
        join
        check_value("dump error flag", 0, err);
    endtask

    task automatic check_dump_shape(input int depth);
        check_value("word count", depth, dump_words.size());
        foreach (dump_lasts[i])
            check_value($sformatf("last flag of word %0d", i), (i == depth - 1), dump_lasts[i]);
    endtask

    task automatic drop_gate(input int low_cycles);
        do @(negedge clock); while (status != SAMPLE);
        repeat (3) @(posedge clock);
        gate <= 1'b0;
        repeat (low_cycles) @(posedge clock);
        gate <= 1'b1;
    endtask

    // ========================================
    // Tests
    // ========================================
    initial begin
        logic                 cmd_err;
        logic [DATA_SIZE-1:0] step;
        int                   big_steps;
        cmd_req = 1'b0;
        cmd = '0;
        ref_sample = '0;
        err_sample = ERR_MASK;
        gate = 1'b0;
        dump_ack = 1'b0;
        lfsr = LFSR_SEED;
        cycles = 0;
        checks = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;

        start_test("reset_state");
        do @(negedge clock); while (!arst_n);
        check_value("cmd ack", 0, cmd_ack);
        check_value("dump req", 0, dump_req);
        check_value("resp", 0, resp);
        while (status != INIT) @(negedge clock);
        @(negedge clock);
        check_value("status after INIT", IDLE, status);
        finish_test();

        start_test("capture_decimate_3");
        send_cmd(OP_SET_MEM, 12'd8, cmd_err);
        check_value("set depth error flag", 0, cmd_err);
        send_cmd(OP_SET_DEC, 12'd3, cmd_err);
        check_value("set factor error flag", 0, cmd_err);
        @(posedge clock);
        gate <= 1'b1;
        send_cmd(OP_SAMPLE, '0, cmd_err);
        check_value("sample error flag", 0, cmd_err);
        run_dump(OP_DUMP_REF);
        check_dump_shape(8);
        for (int i = 1; i < dump_words.size(); i++) begin
            step = dump_words[i] - dump_words[i-1];
            check_value($sformatf("step %0d", i), 3, step);
        end
        ref_words = dump_words;
        finish_test();

        start_test("dump_error_lane");
        run_dump(OP_DUMP_ERR);
        check_dump_shape(8);
        foreach (dump_words[i])
            if (i < ref_words.size())
                check_value($sformatf("error word %0d", i), ref_words[i] ^ ERR_MASK,
                            dump_words[i]);
        finish_test();

        start_test("gate_gap");
        send_cmd(OP_SET_DEC, 12'd1, cmd_err);
        check_value("set factor error flag", 0, cmd_err);
        fork
            send_cmd(OP_SAMPLE, '0, cmd_err);
            drop_gate(5);
        join
        check_value("sample error flag", 0, cmd_err);
        run_dump(OP_DUMP_REF);
        check_dump_shape(8);
        big_steps = 0;
        for (int i = 1; i < dump_words.size(); i++) begin
            step = dump_words[i] - dump_words[i-1];
            check_at_least($sformatf("step %0d", i), 1, int'(step));
            if (step > 1)
                big_steps++;
        end
        check_value("steps above one", 1, big_steps);
        finish_test();

        start_test("clear_memory");
        send_cmd(OP_CLEAN_MEM, '0, cmd_err);
        check_value("clear error flag", 0, cmd_err);
        run_dump(OP_DUMP_REF);
        check_dump_shape(8);
        foreach (dump_words[i])
            check_value($sformatf("cleared word %0d", i), 0, dump_words[i]);
        finish_test();

        start_test("invalid_and_halt");
        send_cmd(iagc_opcode_e'(4'hc), '0, cmd_err);
        check_value("invalid opcode error flag", 1, cmd_err);
        send_cmd(OP_HALT, '0, cmd_err);
        check_value("halt error flag", 0, cmd_err);
        send_cmd(OP_SET_MEM, 12'd4, cmd_err);   // Refused while halted
        check_value("set depth after halt error flag", 1, cmd_err);
        repeat (4) @(negedge clock);
        check_value("status after halt", HALT, status);
        finish_test();

        $display("Tests run %0d, failed %0d; checks %0d, errors %0d; assertion failures %0d",
                 tests_run, tests_failed, checks, errors, dut_i.asserts_i.fail_count);
        if (errors == 0 && dut_i.asserts_i.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic o_clock,
    output logic o_arst_n
);

    // 10 ns period
    initial begin
        o_clock = 1'b0;
        forever #5 o_clock = ~o_clock;
    end

    initial begin
        o_arst_n = 1'b0;
        repeat (3) @(posedge o_clock);
        o_arst_n <= 1'b1;   // Released on an edge
    end

endmodule

//--- iagc_asserts.sv
`timescale 1ns/10ps

module iagc_asserts
    import iagc_pkg::*;
(
    input logic         i_clock,
    input logic         i_arst_n,
    input logic         i_cmd_req,
    input iagc_cmd_t    i_cmd,
    input logic         i_cmd_ack,
    input logic         i_dump_req,
    input iagc_dump_t   i_dump,
    input logic         i_dump_ack,
    input iagc_status_e i_status,
    input sample_wr_t   i_wr,
    input sample_wr_t   i_clr
);

    int fail_count = 0;   // Read by the testbench at the end

    // ========================================
    // Handshakes
    // ========================================
    cmd_ack_needs_req: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $rose(i_cmd_ack) |-> i_cmd_req)
        else begin
            fail_count++;
            $error("Command ack rose while no command request was pending");
        end

    dump_ack_needs_req: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $rose(i_dump_ack) |-> i_dump_req)
        else begin
            fail_count++;
            $error("Dump ack rose while no dump word was offered");
        end

    cmd_req_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_cmd_req && !i_cmd_ack |=> i_cmd_req && $stable(i_cmd))
        else begin
            fail_count++;
            $error("Command request or command changed before the ack");
        end

    dump_req_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_dump_req && !i_dump_ack |=> i_dump_req && $stable(i_dump))
        else begin
            fail_count++;
            $error("Dump request or dump word changed before the ack");
        end

    // ========================================
    // Memory ports and halt
    // ========================================
    one_writer: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !(i_wr.en && i_clr.en))
        else begin
            fail_count++;
            $error("Capture write and clear write were enabled together");
        end

    halt_sticky: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_status == HALT |=> i_status == HALT)
        else begin
            fail_count++;
            $error("Status left HALT without a reset");
        end

endmodule

bind iagc_top iagc_asserts asserts_i (
    .i_clock    (i_clock),
    .i_arst_n   (i_arst_n),
    .i_cmd_req  (i_cmd_req),
    .i_cmd      (i_cmd),
    .i_cmd_ack  (o_cmd_ack),
    .i_dump_req (o_dump_req),
    .i_dump     (o_dump),
    .i_dump_ack (i_dump_ack),
    .i_status   (o_status),
    .i_wr       (wr),
    .i_clr      (clr)
);

//--- iagc_top.sv
`timescale 1ns/10ps

module iagc_top
    import iagc_pkg::*;
(
    input  logic                 i_clock,
    input  logic                 i_arst_n,
    input  logic                 i_cmd_req,
    input  iagc_cmd_t            i_cmd,
    input  logic [DATA_SIZE-1:0] i_reference,
    input  logic [DATA_SIZE-1:0] i_error,
    input  logic                 i_gate,
    input  logic                 i_dump_ack,
    output logic                 o_cmd_ack,
    output iagc_resp_t           o_resp,
    output iagc_status_e         o_status,
    output logic                 o_dump_req,
    output iagc_dump_t           o_dump
);

    logic [ADDR_SIZE-1:0] memory_size;
    logic [DEC_SIZE-1:0]  decimator;
    logic                 sampler_end;
    sample_wr_t           wr;
    sample_wr_t           clr;
    sample_rd_t           rd;
    sample_pair_t         rd_data;

    // ========================================
    // Command and dump control
    // ========================================
    iagc_controller controller_i (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_cmd_req     (i_cmd_req),
        .i_cmd         (i_cmd),
        .i_sampler_end (sampler_end),
        .i_rd_data     (rd_data),
        .i_dump_ack    (i_dump_ack),
        .o_cmd_ack     (o_cmd_ack),
        .o_resp        (o_resp),
        .o_status      (o_status),
        .o_memory_size (memory_size),
        .o_decimator   (decimator),
        .o_clr         (clr),
        .o_rd          (rd),
        .o_dump_req    (o_dump_req),
        .o_dump        (o_dump)
    );

    iagc_sampler sampler_i (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_status      (o_status),
        .i_reference   (i_reference),
        .i_error       (i_error),
        .i_gate        (i_gate),
        .i_memory_size (memory_size),
        .i_decimator   (decimator),
        .o_wr          (wr),
        .o_end         (sampler_end)
    );

    iagc_sample_ram sample_ram_i (
        .i_clock   (i_clock),
        .i_wr      (wr),
        .i_clr     (clr),
        .i_rd      (rd),
        .o_rd_data (rd_data)
    );

endmodule

//--- iagc_controller.sv
`timescale 1ns/10ps

module iagc_controller
    import iagc_pkg::*;
(
    input  logic                 i_clock,
    input  logic                 i_arst_n,
    input  logic                 i_cmd_req,
    input  iagc_cmd_t            i_cmd,
    input  logic                 i_sampler_end,
    input  sample_pair_t         i_rd_data,
    input  logic                 i_dump_ack,
    output logic                 o_cmd_ack,
    output iagc_resp_t           o_resp,
    output iagc_status_e         o_status,
    output logic [ADDR_SIZE-1:0] o_memory_size,
    output logic [DEC_SIZE-1:0]  o_decimator,
    output sample_wr_t           o_clr,
    output sample_rd_t           o_rd,
    output logic                 o_dump_req,
    output iagc_dump_t           o_dump
);

    iagc_cmd_t            cmd_q;
    logic [ADDR_SIZE-1:0] ptr;          // Clear address or next dump read
    logic [ADDR_SIZE-1:0] last_addr;
    logic                 dumping;
    logic                 rd_fire;
    logic                 fetch_done;   // Last read issued
    logic                 pf_pending;
    logic                 pf_valid;
    logic                 pf_last;
    logic [DATA_SIZE-1:0] pf_data;
    logic [DATA_SIZE-1:0] lane_data;

    assign last_addr = o_memory_size - 1'b1;
    assign dumping   = (o_status == DUMP_REF) || (o_status == DUMP_ERR);
    assign rd_fire   = dumping && !pf_valid && !pf_pending && !fetch_done;
    assign lane_data = (o_status == DUMP_ERR) ? i_rd_data.err_data : i_rd_data.ref_data;

    always_comb begin
        o_rd.en        = rd_fire;
        o_rd.addr      = ptr;
        o_clr.en       = (o_status == CLEAN_MEM);
        o_clr.addr     = ptr;
        o_clr.ref_data = '0;
        o_clr.err_data = '0;
    end

    // ========================================
    // Status machine
    // ========================================
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_status      <= RESET;
            o_cmd_ack     <= 1'b0;
            o_resp        <= '0;
            o_memory_size <= DEPTH_RST;
            o_decimator   <= DEC_RST;
            ptr           <= '0;
            fetch_done    <= 1'b0;
            pf_pending    <= 1'b0;
            pf_valid      <= 1'b0;
            pf_last       <= 1'b0;
            o_dump_req    <= 1'b0;
            o_dump        <= '0;
        end else begin
            case (o_status)
                RESET: o_status <= INIT;
                INIT:  o_status <= IDLE;
                IDLE: begin
                    if (o_cmd_ack) begin
                        if (!i_cmd_req)
                            o_cmd_ack <= 1'b0;   // Close previous handshake
                    end else if (i_cmd_req) begin
                        o_status <= CMD_READ;
                    end
                end
                CMD_READ: o_status <= CMD_PARSE;
                CMD_PARSE: begin
                    ptr        <= '0;
                    fetch_done <= 1'b0;
                    pf_pending <= 1'b0;
                    pf_valid   <= 1'b0;
                    o_dump     <= '0;
                    case (cmd_q.opcode)
                        OP_SAMPLE:    o_status <= SAMPLE;
                        OP_DUMP_REF:  o_status <= DUMP_REF;
                        OP_DUMP_ERR:  o_status <= DUMP_ERR;
                        OP_CLEAN_MEM: o_status <= CLEAN_MEM;
                        OP_SET_MEM:   o_status <= SET_MEM;
                        OP_SET_DEC:   o_status <= SET_DEC;
                        OP_HALT: begin
                            o_status     <= HALT;
                            o_cmd_ack    <= 1'b1;
                            o_resp.error <= 1'b0;
                        end
                        default:      o_status <= CMD_ERROR;
                    endcase
                end
                CMD_ERROR: begin
                    o_cmd_ack    <= 1'b1;
                    o_resp.error <= 1'b1;
                    o_status     <= IDLE;
                end
                SAMPLE: begin
                    if (i_sampler_end) begin
                        o_cmd_ack    <= 1'b1;
                        o_resp.error <= 1'b0;
                        o_status     <= IDLE;
                    end
                end
                SET_MEM, SET_DEC: begin
                    if (o_status == SET_MEM)
                        o_memory_size <= cmd_q.arg;
                    else
                        o_decimator <= cmd_q.arg[DEC_SIZE-1:0];
                    o_cmd_ack    <= 1'b1;
                    o_resp.error <= 1'b0;
                    o_status     <= IDLE;
                end
                CLEAN_MEM: begin
                    ptr <= ptr + 1'b1;   // One entry per cycle
                    if (ptr == ADDR_SIZE'(MEM_DEPTH - 1)) begin
                        o_cmd_ack    <= 1'b1;
                        o_resp.error <= 1'b0;
                        o_status     <= IDLE;
                    end
                end
                DUMP_REF, DUMP_ERR: begin
                    if (rd_fire) begin
                        ptr        <= ptr + 1'b1;
                        pf_pending <= 1'b1;
                        fetch_done <= (ptr == last_addr);
                    end
                    if (pf_pending) begin
                        pf_pending <= 1'b0;
                        pf_valid   <= 1'b1;
                        pf_last    <= fetch_done;
                    end
                    if (o_dump_req) begin
                        if (i_dump_ack)
                            o_dump_req <= 1'b0;
                    end else if (!i_dump_ack) begin
                        if (o_dump.last) begin
                            o_cmd_ack    <= 1'b1;   // Final word taken
                            o_resp.error <= 1'b0;
                            o_status     <= IDLE;
                        end else if (pf_valid) begin
                            o_dump_req  <= 1'b1;
                            o_dump.data <= pf_data;
                            o_dump.last <= pf_last;
                            pf_valid    <= 1'b0;
                        end
                    end
                end
                HALT: begin
                    // Stuck until reset, every command refused
                    if (!o_cmd_ack && i_cmd_req) begin
                        o_cmd_ack    <= 1'b1;
                        o_resp.error <= 1'b1;
                    end else if (o_cmd_ack && !i_cmd_req) begin
                        o_cmd_ack <= 1'b0;
                    end
                end
                default: o_status <= RESET;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (o_status == CMD_READ)
            cmd_q <= i_cmd;
        if (pf_pending)
            pf_data <= lane_data;   // Word arrives a cycle after the read
    end

endmodule

//--- iagc_sample_ram.sv
`timescale 1ns/10ps

module iagc_sample_ram
    import iagc_pkg::*;
(
    input  logic         i_clock,
    input  sample_wr_t   i_wr,
    input  sample_wr_t   i_clr,
    input  sample_rd_t   i_rd,
    output sample_pair_t o_rd_data
);

    logic [DATA_SIZE-1:0] ref_mem [MEM_DEPTH];
    logic [DATA_SIZE-1:0] err_mem [MEM_DEPTH];
    sample_wr_t           wr_sel;

    // Clear port wins
    always_comb begin
        if (i_clr.en)
            wr_sel = i_clr;
        else
            wr_sel = i_wr;
    end

    // ========================================
    // Lanes
    // ========================================
    always_ff @(posedge i_clock) begin
        if (wr_sel.en) begin
            ref_mem[wr_sel.addr] <= wr_sel.ref_data;
            err_mem[wr_sel.addr] <= wr_sel.err_data;
        end
    end

    // Registered read, one cycle
    always_ff @(posedge i_clock) begin
        if (i_rd.en) begin
            o_rd_data.ref_data <= ref_mem[i_rd.addr];
            o_rd_data.err_data <= err_mem[i_rd.addr];
        end
    end

endmodule

//--- iagc_sampler.sv
`timescale 1ns/10ps

module iagc_sampler
    import iagc_pkg::*;
(
    input  logic                 i_clock,
    input  logic                 i_arst_n,
    input  iagc_status_e         i_status,
    input  logic [DATA_SIZE-1:0] i_reference,
    input  logic [DATA_SIZE-1:0] i_error,
    input  logic                 i_gate,
    input  logic [ADDR_SIZE-1:0] i_memory_size,
    input  logic [DEC_SIZE-1:0]  i_decimator,
    output sample_wr_t           o_wr,
    output logic                 o_end
);

    sampler_state_e       state;
    sampler_state_e       next_state;
    logic [ADDR_SIZE-1:0] addr;         // Last written address
    logic [ADDR_SIZE-1:0] wr_addr;
    logic [DEC_SIZE-1:0]  dec_cnt;
    logic [DEC_SIZE-1:0]  dec_last;
    logic [1:0]           end_cnt;
    logic                 first_write;
    logic                 last_gate;
    logic                 gate_rise;
    logic                 do_write;
    logic                 wr_en_q;
    logic [ADDR_SIZE-1:0] wr_addr_q;
    logic [DATA_SIZE-1:0] wr_ref_q;
    logic [DATA_SIZE-1:0] wr_err_q;

    // Factor 0 behaves as 1
    assign dec_last  = (i_decimator == '0) ? '0 : i_decimator - 1'b1;
    assign wr_addr   = first_write ? '0 : addr + 1'b1;
    assign gate_rise = i_gate & ~last_gate;
    assign do_write  = (state == ST_WRITE) && i_gate && (dec_cnt >= dec_last);

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        next_state = state;
        case (state)
            ST_INIT: begin
                if (i_status == SAMPLE)
                    next_state = ST_WRITE;
            end
            ST_WAIT: begin
                if (gate_rise)
                    next_state = ST_WRITE;
            end
            ST_WRITE: begin
                if (do_write && wr_addr == i_memory_size - 1'b1)
                    next_state = ST_END;   // Depth filled
                else if (!i_gate)
                    next_state = ST_WAIT;
            end
            ST_END: begin
                if (end_cnt == 2'd3)
                    next_state = ST_INIT;
            end
            default: next_state = ST_INIT;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state       <= ST_INIT;
            addr        <= '0;
            dec_cnt     <= '0;
            end_cnt     <= '0;
            first_write <= 1'b1;
            last_gate   <= 1'b0;
            wr_en_q     <= 1'b0;
        end else if (i_status == RESET) begin
            state       <= ST_INIT;
            addr        <= '0;
            dec_cnt     <= '0;
            end_cnt     <= '0;
            first_write <= 1'b1;
            last_gate   <= i_gate;
            wr_en_q     <= 1'b0;
        end else begin
            state     <= next_state;
            last_gate <= i_gate;
            wr_en_q   <= do_write;
            end_cnt   <= (state == ST_END) ? end_cnt + 1'b1 : 2'd0;
            if (do_write) begin
                addr        <= wr_addr;
                first_write <= 1'b0;
            end
            if (state == ST_INIT || state == ST_END) begin
                addr        <= '0;
                first_write <= 1'b1;
            end
            if (state == ST_WRITE && i_gate && !do_write)
                dec_cnt <= dec_cnt + 1'b1;
            else
                dec_cnt <= '0;
        end
    end

    // Captured pair
    always_ff @(posedge i_clock) begin
        if (do_write) begin
            wr_addr_q <= wr_addr;
            wr_ref_q  <= i_reference;
            wr_err_q  <= i_error;
        end
    end

    always_comb begin
        o_wr.en       = wr_en_q;
        o_wr.addr     = wr_addr_q;
        o_wr.ref_data = wr_ref_q;
        o_wr.err_data = wr_err_q;
    end

    assign o_end = (state == ST_END);

endmodule

//--- iagc_pkg.sv
package iagc_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int DATA_SIZE = 16;
    localparam int ADDR_SIZE = 12;
    localparam int DEC_SIZE  = 4;
    localparam int MEM_DEPTH = 1 << ADDR_SIZE;   // Entries per lane

    localparam logic [ADDR_SIZE-1:0] DEPTH_RST = 12'd16;
    localparam logic [DEC_SIZE-1:0]  DEC_RST   = 4'd1;

    // ========================================
    // Encodings
    // ========================================
    typedef enum logic [3:0] {
        RESET     = 4'b0000,
        INIT      = 4'b0001,
        IDLE      = 4'b0010,
        SAMPLE    = 4'b0011,
        CMD_PARSE = 4'b0100,
        CMD_READ  = 4'b0101,
        CMD_ERROR = 4'b0110,
        DUMP_REF  = 4'b0111,
        DUMP_ERR  = 4'b1000,
        CLEAN_MEM = 4'b1001,
        SET_MEM   = 4'b1010,
        SET_DEC   = 4'b1011,
        HALT      = 4'b1100
    } iagc_status_e;

    // Codes 0 and 8..15 are invalid
    typedef enum logic [3:0] {
        OP_SAMPLE    = 4'h1,
        OP_DUMP_REF  = 4'h2,
        OP_DUMP_ERR  = 4'h3,
        OP_CLEAN_MEM = 4'h4,
        OP_SET_MEM   = 4'h5,
        OP_SET_DEC   = 4'h6,
        OP_HALT      = 4'h7
    } iagc_opcode_e;

    typedef enum logic [1:0] {
        ST_INIT  = 2'd0,
        ST_WAIT  = 2'd1,
        ST_WRITE = 2'd2,
        ST_END   = 2'd3
    } sampler_state_e;

    // ========================================
    // Bundles
    // ========================================
    typedef struct packed {
        iagc_opcode_e         opcode;
        logic [ADDR_SIZE-1:0] arg;   // Depth or decimation factor
    } iagc_cmd_t;

    typedef struct packed {
        logic error;
    } iagc_resp_t;

    typedef struct packed {
        logic [DATA_SIZE-1:0] data;
        logic                 last;
    } iagc_dump_t;

    typedef struct packed {
        logic                 en;
        logic [ADDR_SIZE-1:0] addr;
        logic [DATA_SIZE-1:0] ref_data;
        logic [DATA_SIZE-1:0] err_data;
    } sample_wr_t;

    typedef struct packed {
        logic                 en;
        logic [ADDR_SIZE-1:0] addr;
    } sample_rd_t;

    typedef struct packed {
        logic [DATA_SIZE-1:0] ref_data;
        logic [DATA_SIZE-1:0] err_data;
    } sample_pair_t;

endpackage
